//--- hw/pad_uart_pkg.sv
// Shared widths, timing constants and types for the pad to UART bridge, imported by every block
package pad_uart_pkg;

    // Pad geometry and UART character size
    localparam int num_buttons = 12;
    localparam int byte_w      = 8;

    // UART frame is start bit, data bits and stop bit
    localparam int frame_w = byte_w + 2;

    // Cycles per UART bit, kept short so simulation stays fast
    localparam int clks_per_bit = 8;

    // Half period of the pad clock, also the length of the latch pulse
    localparam int pad_half = 4;

    // Idle cycles between the end of a scan and the next latch pulse
    localparam int scan_gap = 16;

    // Length of one full scan in cycles (108 with the values above)
    localparam int scan_cycles = pad_half + (num_buttons - 1) * 2 * pad_half + scan_gap;

    // Counter widths derived from the constants above
    localparam int phase_w     = $clog2(scan_gap);
    localparam int btn_idx_w   = $clog2(num_buttons);
    localparam int bit_time_w  = $clog2(clks_per_bit);
    localparam int frame_idx_w = $clog2(frame_w);

    // Bit i set means button i is held
    typedef logic [num_buttons-1:0] buttons_t;
    typedef logic [byte_w-1:0]      char_t;

    // Button 0 sends 'A', button i sends 'A' plus i
    localparam char_t char_base = 8'h41;

endpackage

//--- hw/pad_scanner.sv
// Serial pad poller that drives latch and clock, shifts in twelve buttons and publishes them per scan
module pad_scanner (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  pad_latch,
    output logic                  pad_clk,
    input  logic                  pad_data,
    output pad_uart_pkg::buttons_t buttons
);
    import pad_uart_pkg::*;

    // Latch pulse, low and high halves of the pad clock, then the idle gap
    typedef enum logic [1:0] {
        st_latch,
        st_low,
        st_high,
        st_gap
    } scan_state_t;

    scan_state_t           state;
    logic [phase_w-1:0]    phase;
    logic [btn_idx_w-1:0]  bit_idx;
    buttons_t              shift_q;
    logic                  scan_done;
    logic                  half_end;
    logic                  gap_end;
    logic                  last_bit;

    // Both pins decode straight from the state register
    assign pad_latch = (state == st_latch);
    assign pad_clk   = (state != st_low);

    assign half_end = (phase == phase_w'(pad_half - 1));
    assign gap_end  = (phase == phase_w'(scan_gap - 1));
    assign last_bit = (bit_idx == btn_idx_w'(num_buttons - 1));

    // Sequencer for one scan; starts in the gap so the pins come out of reset idle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_gap;
            phase     <= '0;
            bit_idx   <= '0;
            scan_done <= 1'b0;
        end else begin
            phase     <= phase + 1'b1;
            scan_done <= 1'b0;
            case (state)
                st_latch: begin
                    // Button 0 was sampled in this last latch cycle
                    if (half_end) begin
                        phase   <= '0;
                        bit_idx <= btn_idx_w'(1);
                        state   <= st_low;
                    end
                end
                st_low: begin
                    if (half_end) begin
                        phase <= '0;
                        state <= st_high;
                    end
                end
                st_high: begin
                    if (half_end) begin
                        phase <= '0;
                        if (last_bit) begin
                            state     <= st_gap;
                            scan_done <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            state   <= st_low;
                        end
                    end
                end
                default: begin
                    if (gap_end) begin
                        phase   <= '0;
                        bit_idx <= '0;
                        state   <= st_latch;
                    end
                end
            endcase
        end
    end

    // Pad data is active low, so each sample is inverted
    // Shifting in at the top leaves button 0 at bit 0 after twelve samples
    always_ff @(posedge clk) begin
        if (half_end && (state == st_latch || state == st_high)) begin
            shift_q <= {~pad_data, shift_q[num_buttons-1:1]};
        end
    end

    // Copy the whole scan at once so the encoder never sees a partial update
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buttons <= '0;
        end else if (scan_done) begin
            buttons <= shift_q;
        end
    end

endmodule

//--- hw/button_event_encoder.sv
// Turns new button presses into ASCII characters and hands them one at a time to the UART transmitter
module button_event_encoder (
    input  logic                   clk,
    input  logic                   reset,
    input  pad_uart_pkg::buttons_t buttons,
    input  logic                   tx_ready,
    output pad_uart_pkg::char_t    tx_data,
    output logic                   tx_valid
);
    import pad_uart_pkg::*;

    buttons_t             buttons_prev;
    buttons_t             pending;
    buttons_t             rise;
    buttons_t             pick_mask;
    logic [btn_idx_w-1:0] pick_idx;
    logic                 send;

    // A bit that is set now but was clear last cycle is a fresh press
    assign rise = buttons & ~buttons_prev;

    // Lowest pending index wins; scanning downward lets the lowest one overwrite
    always_comb begin
        pick_idx = '0;
        for (int i = num_buttons - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick_idx = btn_idx_w'(i);
            end
        end
    end

    assign pick_mask = buttons_t'(1) << pick_idx;

    // Skip the cycle right after a strobe, since tx_ready only drops one cycle later
    assign send = tx_ready && !tx_valid && (pending != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buttons_prev <= '0;
            pending      <= '0;
            tx_valid     <= 1'b0;
        end else begin
            buttons_prev <= buttons;
            tx_valid     <= send;
            // New presses are ORed in after the clear, so they merge instead of getting lost
            if (send) begin
                pending <= (pending & ~pick_mask) | rise;
            end else begin
                pending <= pending | rise;
            end
        end
    end

    // Character for the chosen button, valid alongside the strobe
    always_ff @(posedge clk) begin
        if (send) begin
            tx_data <= char_base + char_t'(pick_idx);
        end
    end

endmodule

//--- hw/uart_tx.sv
// 8N1 UART transmitter taking one byte per valid strobe while ready is high
module uart_tx (
    input  logic                clk,
    input  logic                reset,
    input  pad_uart_pkg::char_t tx_data,
    input  logic                tx_valid,
    output logic                tx_ready,
    output logic                uart_txd
);
    import pad_uart_pkg::*;

    logic                   busy;
    logic [bit_time_w-1:0]  bit_cnt;
    logic [frame_idx_w-1:0] bit_idx;
    logic                   bit_end;
    logic                   accept;

    // Remaining frame bits after the start bit: data LSB first, stop bit on top
    logic [byte_w:0]        shreg;

    assign tx_ready = ~busy;
    assign accept   = tx_valid && tx_ready;
    assign bit_end  = (bit_cnt == bit_time_w'(clks_per_bit - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            uart_txd <= 1'b1;
        end else if (accept) begin
            // Start bit goes out in the very next cycle
            busy     <= 1'b1;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            uart_txd <= 1'b0;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_end) begin
                bit_cnt <= '0;
                if (bit_idx == frame_idx_w'(frame_w - 1)) begin
                    // Stop bit is done and the line is already high
                    busy     <= 1'b0;
                    uart_txd <= 1'b1;
                end else begin
                    bit_idx  <= bit_idx + 1'b1;
                    uart_txd <= shreg[0];
                end
            end
        end
    end

    // Byte plus stop bit, loaded on accept and consumed one bit per bit time
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= {1'b1, tx_data};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[byte_w:1]};
        end
    end

endmodule

//--- hw/pad_uart_top.sv
// Chip top that links the pad scanner, press encoder and UART transmitter to the pins
module pad_uart_top (
    input  logic clk,
    input  logic reset,
    output logic pad_latch,
    output logic pad_clk,
    input  logic pad_data,
    output logic uart_txd
);
    import pad_uart_pkg::*;

    // Debounced button state, updated once per scan
    buttons_t buttons;

    // Strobe handshake between encoder and transmitter
    char_t    tx_data;
    logic     tx_valid;
    logic     tx_ready;

    // Polls the pad and holds the latest full scan
    pad_scanner u_pad_scanner (
        .clk       (clk),
        .reset     (reset),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_data  (pad_data),
        .buttons   (buttons)
    );

    // Queues new presses and emits one character per free transmitter slot
    button_event_encoder u_button_event_encoder (
        .clk      (clk),
        .reset    (reset),
        .buttons  (buttons),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    // Serializes each character onto the line
    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .uart_txd (uart_txd)
    );

endmodule

//--- dv/pad_uart_assert.sv
// Strobe and line checks on the encoder to transmitter handshake, bound into each uart_tx
module pad_uart_assert (
    input logic clk,
    input logic reset,
    input logic tx_valid,
    input logic tx_ready,
    input logic uart_txd
);

    // The encoder leaves at least one idle cycle between strobes
    property valid_single_cycle;
        @(posedge clk) disable iff (reset) tx_valid |=> !tx_valid;
    endproperty

    // A strobe only follows a cycle in which the transmitter was idle
    property valid_after_ready;
        @(posedge clk) disable iff (reset) tx_valid |-> $past(tx_ready);
    endproperty

    // An idle transmitter always holds the line at the mark level
    property idle_line_high;
        @(posedge clk) disable iff (reset) tx_ready |-> uart_txd;
    endproperty

    assert property (valid_single_cycle) else $error("tx_valid high in two consecutive cycles");
    assert property (valid_after_ready) else $error("tx_valid raised without prior tx_ready");
    assert property (idle_line_high) else $error("uart_txd low while transmitter idle");

endmodule

bind uart_tx pad_uart_assert u_pad_uart_assert (
    .clk      (clk),
    .reset    (reset),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .uart_txd (uart_txd)
);

//--- dv/pad_uart_tb.sv
// Self-checking testbench for the pad to UART bridge, with a pad model and a UART receiver
module pad_uart_tb;
    import pad_uart_pkg::*;

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    logic     pad_latch;
    logic     pad_clk;
    logic     pad_data;
    logic     uart_txd;

    // Buttons held on the model pad and the pad's own shift register
    buttons_t pad_state = '0;
    buttons_t pad_shift = '0;

    char_t    expected[$];
    char_t    received[$];

    string    test_name = "reset";
    int       errors = 0;
    int       test_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;

    // Receiver state with a cycle count that runs from the detected start bit
    logic     rx_active = 1'b0;
    int       rx_cnt = 0;
    int       rx_pos = 0;
    char_t    rx_byte = '0;

    always #10 clk = ~clk;

    pad_uart_top u_pad_uart_top (
        .clk       (clk),
        .reset     (reset),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_data  (pad_data),
        .uart_txd  (uart_txd)
    );

    // Pad copies its buttons on latch and moves to the next button on each rising pad clock
    always @(posedge pad_clk or posedge pad_latch) begin
        if (pad_latch) begin
            pad_shift <= pad_state;
        end else begin
            pad_shift <= {1'b0, pad_shift[num_buttons-1:1]};
        end
    end

    // Pressed buttons pull the data line low
    assign pad_data = ~pad_shift[0];

    // Character that a press of button idx should produce
    function automatic char_t expected_char(input int idx);
        return char_base + char_t'(idx);
    endfunction

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_char(input string what, input char_t exp, input char_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected 0x%02h actual 0x%02h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // Mid-bit sampling; bit position 0 is the start bit and the last one is the stop bit
    always @(posedge clk) begin
        if (reset) begin
            rx_active = 1'b0;
            rx_cnt = 0;
        end else if (!rx_active) begin
            if (uart_txd == 1'b0) begin
                rx_active = 1'b1;
                rx_cnt = 1;
            end
        end else begin
            rx_cnt = rx_cnt + 1;
            if (rx_cnt % clks_per_bit == clks_per_bit / 2) begin
                rx_pos = rx_cnt / clks_per_bit;
                if (rx_pos == 0) begin
                    check_level("start bit", 1'b0, uart_txd);
                end else if (rx_pos <= byte_w) begin
                    rx_byte[rx_pos - 1] = uart_txd;
                end else begin
                    check_level("stop bit", 1'b1, uart_txd);
                    received.push_back(rx_byte);
                    rx_active = 1'b0;
                end
            end
        end
    end

    // Every received character must match the oldest outstanding prediction
    always @(posedge clk) begin
        if (received.size() > 0) begin
            if (expected.size() == 0) begin
                report_problem($sformatf("%s: unexpected character 0x%02h arrived",
                                         test_name, received[0]));
                void'(received.pop_front());
            end else begin
                check_char("character", expected.pop_front(), received.pop_front());
            end
        end
    end

    // New pad state just after a clock edge; rising bits are predicted lowest index first
    task automatic set_pad(input buttons_t next_state);
        @(posedge clk);
        #1;
        for (int i = 0; i < num_buttons; i++) begin
            if (next_state[i] && !pad_state[i]) begin
                expected.push_back(expected_char(i));
            end
        end
        pad_state = next_state;
    endtask

    task automatic apply_pad(input buttons_t next_state, input int scans);
        set_pad(next_state);
        repeat (scans * scan_cycles - 1) @(posedge clk);
    endtask

    task automatic wait_drain(input int max_cycles);
        bit drained;
        drained = 1'b0;
        for (int c = 0; c < max_cycles && !drained; c++) begin
            @(posedge clk);
            #1;
            drained = (expected.size() == 0) && (received.size() == 0) && !rx_active;
        end
        if (!drained) begin
            report_problem($sformatf("%s: no character arrived within %0d cycles, %0d missing",
                                     test_name, max_cycles, expected.size()));
            expected.delete();
        end
    endtask

    task automatic wait_frame_start(input int max_cycles);
        bit started;
        started = 1'b0;
        for (int c = 0; c < max_cycles && !started; c++) begin
            @(posedge clk);
            #1;
            started = (uart_txd == 1'b0);
        end
        if (!started) begin
            report_problem($sformatf("%s: no character arrived, the line never left idle",
                                     test_name));
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d errors", test_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        int       btn;
        int       other;
        int       hold;
        int       flips;
        int       latches;
        logic     latch_prev;
        buttons_t next;

        void'($urandom(32'hcf0d));
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle pins after reset and a latch pulse once per scan
        test_name = "idle_after_reset";
        @(posedge clk);
        #1;
        check_level("uart_txd", 1'b1, uart_txd);
        check_level("pad_clk", 1'b1, pad_clk);
        check_level("pad_latch", 1'b0, pad_latch);
        check_level("tx_ready", 1'b1, u_pad_uart_top.tx_ready);
        check_level("tx_valid", 1'b0, u_pad_uart_top.tx_valid);
        latches = 0;
        latch_prev = pad_latch;
        for (int c = 0; c < 3 * scan_cycles; c++) begin
            @(posedge clk);
            #1;
            if (pad_latch && !latch_prev) begin
                latches++;
            end
            latch_prev = pad_latch;
        end
        check_level("three latch pulses", 1'b1, latches == 3);
        check_level("line still idle", 1'b1, uart_txd);
        finish_test();

        // One press gives one character, holding adds nothing, a second press repeats it
        test_name = "single_press";
        btn = int'($urandom % num_buttons);
        apply_pad(buttons_t'(1) << btn, 4);
        wait_drain(2 * scan_cycles);
        apply_pad('0, 2);
        apply_pad(buttons_t'(1) << btn, 3);
        wait_drain(2 * scan_cycles);
        apply_pad('0, 2);
        finish_test();

        // Several buttons in one scan come out lowest index first
        test_name = "multi_press";
        next = buttons_t'($urandom);
        if ($countones(next) < 2) begin
            next = 12'h5a3;
        end
        apply_pad(next, 2);
        wait_drain(num_buttons * frame_w * clks_per_bit + 4 * scan_cycles);
        apply_pad('0, 2);
        finish_test();

        // Two presses start a queue and a third arrives while a frame is on the line
        test_name = "press_while_busy";
        btn = int'($urandom % (num_buttons - 2));
        other = num_buttons - 1;
        set_pad((buttons_t'(1) << btn) | (buttons_t'(1) << (btn + 1)));
        wait_frame_start(3 * scan_cycles);
        set_pad(pad_state | (buttons_t'(1) << other));
        check_level("frame in progress", 1'b0, u_pad_uart_top.tx_ready);
        wait_drain(4 * scan_cycles);
        apply_pad('0, 2);
        finish_test();

        // Random walk where each step flips no more buttons than the scans it is held
        test_name = "random_sequence";
        for (int n = 0; n < 40; n++) begin
            hold = 1 + int'($urandom % 3);
            flips = 1 + int'($urandom % hold);
            next = pad_state;
            repeat (flips) begin
                next = next ^ (buttons_t'(1) << ($urandom % num_buttons));
            end
            apply_pad(next, hold);
        end
        wait_drain(20 * scan_cycles);
        repeat (3 * scan_cycles) @(posedge clk);
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- pad_uart.f
hw/pad_uart_pkg.sv
hw/pad_scanner.sv
hw/button_event_encoder.sv
hw/uart_tx.sv
hw/pad_uart_top.sv
dv/pad_uart_assert.sv
dv/pad_uart_tb.sv

//--- Makefile
TOP := pad_uart_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

obj_dir/V$(TOP): pad_uart.f hw/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f pad_uart.f

lint:
	verilator --lint-only -Wall --top-module pad_uart_top \
		hw/pad_uart_pkg.sv hw/pad_scanner.sv hw/button_event_encoder.sv \
		hw/uart_tx.sv hw/pad_uart_top.sv

clean:
	rm -rf obj_dir
